/* common/adc_pack.sv */
`default_nettype none

package adc_pack;

    // Frame shape of the interleaved ADC
    localparam int n_adc = 8;
    localparam int n_ti  = 4;

    // Raw slice magnitude as delivered next to its sign bit
    typedef logic [n_adc-1:0] adc_mag_t;

    // One extra bit so a full-scale magnitude keeps its sign
    typedef logic signed [n_adc:0] adc_smp_t;

    // Offset lives in the same domain as the unfolded sample
    typedef logic signed [n_adc:0] adc_offset_t;

endpackage

`default_nettype wire

/* common/cdr_pack.sv */
`default_nettype none

package cdr_pack;

    // Phase interpolator code width and output count
    localparam int n_pi  = 8;
    localparam int n_out = 4;

    // Room for n_ti products of two unfolded samples
    localparam int n_pd_err = 2 * (adc_pack::n_adc + 1) + 2;

    // Signed error of one whole frame
    typedef logic signed [n_pd_err-1:0] pd_err_t;

    // Interpolator phase code, wraps like a phase
    typedef logic [n_pi-1:0] pi_code_t;

    // Range value for one interpolator output
    typedef logic [n_pi-1:0] pi_scale_t;

endpackage

`default_nettype wire

/* src/adc_retimer.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_retimer (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire adc_pack::adc_mag_t adc_mag_i [adc_pack::n_ti-1:0],
    input wire logic [adc_pack::n_ti-1:0] adc_sign_i,
    output adc_pack::adc_mag_t mag_o [adc_pack::n_ti-1:0],
    output logic [adc_pack::n_ti-1:0] sign_o
);
    import adc_pack::*;

    // Slices settle at different phases, one edge lines them up
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            for (int k = 0; k < n_ti; k++) begin
                mag_o[k] <= '0;
            end
            sign_o <= '0;
        end else begin
            for (int k = 0; k < n_ti; k++) begin
                mag_o[k] <= adc_mag_i[k];
            end
            sign_o <= adc_sign_i;
        end
    end

endmodule

`default_nettype wire

/* src/adc_unfold.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_unfold #(
    parameter int avg_log2 = 4
) (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire adc_pack::adc_mag_t mag_i [adc_pack::n_ti-1:0],
    input wire logic [adc_pack::n_ti-1:0] sign_i,
    input wire logic en_cal_i,
    input wire logic en_ext_offset_i,
    input wire adc_pack::adc_offset_t ext_offset_i [adc_pack::n_ti-1:0],
    output adc_pack::adc_smp_t smp_o [adc_pack::n_ti-1:0],
    output adc_pack::adc_offset_t offset_o [adc_pack::n_ti-1:0]
);
    import adc_pack::*;

    localparam int n_acc = $bits(adc_smp_t) + avg_log2;

    logic [avg_log2-1:0] win_cnt;
    logic win_last;
    adc_smp_t raw [n_ti-1:0];
    logic signed [n_acc-1:0] acc [n_ti-1:0];
    logic signed [n_acc-1:0] acc_sum [n_ti-1:0];
    adc_offset_t cal_offset [n_ti-1:0];

    assign win_last = &win_cnt;

    always_comb begin
        for (int k = 0; k < n_ti; k++) begin
            // Sign bit high means positive
            if (sign_i[k]) begin
                raw[k] = adc_smp_t'({1'b0, mag_i[k]});
            end else begin
                raw[k] = -adc_smp_t'({1'b0, mag_i[k]});
            end
            acc_sum[k] = acc[k] + raw[k];
            offset_o[k] = en_ext_offset_i ? ext_offset_i[k] : cal_offset[k];
        end
    end

    // Offset-corrected sample register
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            for (int k = 0; k < n_ti; k++) begin
                smp_o[k] <= '0;
            end
        end else begin
            for (int k = 0; k < n_ti; k++) begin
                smp_o[k] <= raw[k] - offset_o[k];
            end
        end
    end

    // Window average of the raw samples, one accumulator per slice
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            win_cnt <= '0;
            for (int k = 0; k < n_ti; k++) begin
                acc[k] <= '0;
                cal_offset[k] <= '0;
            end
        end else if (!en_cal_i) begin
            // Calibrated value held while idle
            win_cnt <= '0;
            for (int k = 0; k < n_ti; k++) begin
                acc[k] <= '0;
            end
        end else begin
            win_cnt <= win_cnt + 1'b1;
            for (int k = 0; k < n_ti; k++) begin
                if (win_last) begin
                    acc[k] <= '0;
                    cal_offset[k] <= adc_offset_t'(acc_sum[k] >>> avg_log2);
                end else begin
                    acc[k] <= acc_sum[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* cdr/mm_pd.sv */
`timescale 1ns/1ps
`default_nettype none

module mm_pd (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire adc_pack::adc_smp_t smp_i [adc_pack::n_ti-1:0],
    output cdr_pack::pd_err_t pd_err_o
);
    import adc_pack::*;
    import cdr_pack::*;

    adc_smp_t prev_last;
    adc_smp_t prev_smp [n_ti-1:0];
    pd_err_t err_sum;

    // Left neighbour of each slice, slice 0 looks back one frame
    assign prev_smp[0] = prev_last;
    for (genvar k = 1; k < n_ti; k++) begin : g_pair
        assign prev_smp[k] = smp_i[k-1];
    end

    always_comb begin
        pd_err_t a_ext;
        pd_err_t b_ext;
        err_sum = '0;
        for (int k = 0; k < n_ti; k++) begin
            a_ext = prev_smp[k];
            b_ext = smp_i[k];
            // a*sgn(b) - b*sgn(a), zero counts as positive
            err_sum = err_sum
                    + (smp_i[k][n_adc] ? -a_ext : a_ext)
                    - (prev_smp[k][n_adc] ? -b_ext : b_ext);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            prev_last <= '0;
            pd_err_o <= '0;
        end else begin
            prev_last <= smp_i[n_ti-1];
            pd_err_o <= err_sum;
        end
    end

endmodule

`default_nettype wire

/* cdr/cdr_loop_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdr_loop_filter #(
    parameter int kp_shift = 2,
    parameter int ki_shift = 6
) (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire logic en_cdr_i,
    input wire cdr_pack::pd_err_t pd_err_i,
    output cdr_pack::pi_code_t pi_code_o
);
    import cdr_pack::*;

    pi_code_t integ;
    pi_code_t integ_next;
    pi_code_t prop_term;
    pi_code_t int_term;

    // Arithmetic shifts keep the error sign, then wrap into code range
    assign int_term   = pi_code_t'(pd_err_i >>> ki_shift);
    assign prop_term  = pi_code_t'(pd_err_i >>> kp_shift);
    assign integ_next = integ + int_term;

    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            integ <= '0;
            pi_code_o <= '0;
        end else if (en_cdr_i) begin
            integ <= integ_next;
            // Phase wraps modulo 2^n_pi
            pi_code_o <= integ_next + prop_term;
        end
    end

endmodule

`default_nettype wire

/* cdr/pi_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module pi_scaler (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire cdr_pack::pi_code_t pi_code_i,
    input wire cdr_pack::pi_code_t ext_pi_offset_i [cdr_pack::n_out-1:0],
    input wire cdr_pack::pi_scale_t ext_scale_i [cdr_pack::n_out-1:0],
    output cdr_pack::pi_code_t pi_ctl_o [cdr_pack::n_out-1:0]
);
    import cdr_pack::*;

    pi_scale_t scale_val [n_out-1:0];
    pi_code_t code_off [n_out-1:0];
    logic [2*n_pi-1:0] scaled [n_out-1:0];

    for (genvar j = 0; j < n_out; j++) begin : g_out
        assign scale_val[j] = ext_scale_i[j] << 4;
        assign code_off[j]  = pi_code_i + ext_pi_offset_i[j];
        assign scaled[j]    = code_off[j] * scale_val[j];
    end

    // Upper half maps the code onto the usable range
    always_ff @(posedge clk_adc) begin
        if (rst_i) begin
            for (int j = 0; j < n_out; j++) begin
                pi_ctl_o[j] <= '0;
            end
        end else begin
            for (int j = 0; j < n_out; j++) begin
                pi_ctl_o[j] <= scaled[j][2*n_pi-1:n_pi];
            end
        end
    end

endmodule

`default_nettype wire

/* src/cdr_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cdr_core #(
    parameter int avg_log2 = 4,
    parameter int kp_shift = 2,
    parameter int ki_shift = 6
) (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire adc_pack::adc_mag_t adc_mag_i [adc_pack::n_ti-1:0],
    input wire logic [adc_pack::n_ti-1:0] adc_sign_i,
    input wire logic en_cal_i,
    input wire logic en_ext_offset_i,
    input wire adc_pack::adc_offset_t ext_offset_i [adc_pack::n_ti-1:0],
    input wire logic en_cdr_i,
    input wire cdr_pack::pi_code_t ext_pi_offset_i [cdr_pack::n_out-1:0],
    input wire cdr_pack::pi_scale_t ext_scale_i [cdr_pack::n_out-1:0],
    output wire adc_pack::adc_smp_t adc_unfolded_o [adc_pack::n_ti-1:0],
    output wire adc_pack::adc_offset_t offset_o [adc_pack::n_ti-1:0],
    output wire cdr_pack::pi_code_t pi_code_o,
    output wire cdr_pack::pi_code_t pi_ctl_o [cdr_pack::n_out-1:0]
);
    import adc_pack::*;
    import cdr_pack::*;

    adc_mag_t mag_rt [n_ti-1:0];
    logic [n_ti-1:0] sign_rt;
    pd_err_t pd_err;

    adc_retimer retimer_i (
        .clk_adc    (clk_adc),
        .rst_i      (rst_i),
        .adc_mag_i  (adc_mag_i),
        .adc_sign_i (adc_sign_i),
        .mag_o      (mag_rt),
        .sign_o     (sign_rt)
    );

    adc_unfold #(.avg_log2(avg_log2)) unfold_i (
        .clk_adc         (clk_adc),
        .rst_i           (rst_i),
        .mag_i           (mag_rt),
        .sign_i          (sign_rt),
        .en_cal_i        (en_cal_i),
        .en_ext_offset_i (en_ext_offset_i),
        .ext_offset_i    (ext_offset_i),
        .smp_o           (adc_unfolded_o),
        .offset_o        (offset_o)
    );

    mm_pd pd_i (
        .clk_adc  (clk_adc),
        .rst_i    (rst_i),
        .smp_i    (adc_unfolded_o),
        .pd_err_o (pd_err)
    );

    cdr_loop_filter #(.kp_shift(kp_shift), .ki_shift(ki_shift)) filt_i (
        .clk_adc   (clk_adc),
        .rst_i     (rst_i),
        .en_cdr_i  (en_cdr_i),
        .pd_err_i  (pd_err),
        .pi_code_o (pi_code_o)
    );

    pi_scaler scaler_i (
        .clk_adc         (clk_adc),
        .rst_i           (rst_i),
        .pi_code_i       (pi_code_o),
        .ext_pi_offset_i (ext_pi_offset_i),
        .ext_scale_i     (ext_scale_i),
        .pi_ctl_o        (pi_ctl_o)
    );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);
    // 40 ns period, reset held for five edges
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* verif/cdr_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module cdr_core_asserts (
    input wire logic clk_adc,
    input wire logic rst_i,
    input wire adc_pack::adc_mag_t adc_mag_i [adc_pack::n_ti-1:0],
    input wire logic [adc_pack::n_ti-1:0] adc_sign_i,
    input wire logic en_ext_offset_i,
    input wire adc_pack::adc_offset_t ext_offset_i [adc_pack::n_ti-1:0],
    input wire logic en_cdr_i,
    input wire cdr_pack::pi_code_t ext_pi_offset_i [cdr_pack::n_out-1:0],
    input wire cdr_pack::pi_scale_t ext_scale_i [cdr_pack::n_out-1:0],
    input wire adc_pack::adc_smp_t adc_unfolded_o [adc_pack::n_ti-1:0],
    input wire adc_pack::adc_offset_t offset_o [adc_pack::n_ti-1:0],
    input wire cdr_pack::pi_code_t pi_code_o,
    input wire cdr_pack::pi_code_t pi_ctl_o [cdr_pack::n_out-1:0]
);
    import adc_pack::*;
    import cdr_pack::*;

    function automatic int signed_mag(adc_mag_t m, logic s);
        return s ? int'(m) : -int'(m);
    endfunction

    function automatic int wrap9(int v);
        adc_smp_t t;
        t = adc_smp_t'(v);
        return int'(t);
    endfunction

    function automatic int ctl_value(int code, int off, int scl);
        int mask;
        mask = (1 << n_pi) - 1;
        return (((code + off) & mask) * ((scl << 4) & mask)) >> n_pi;
    endfunction

    a_reset: assert property (@(posedge clk_adc)
        rst_i |=> pi_code_o == '0)
        else $error("pi_code_o not cleared by reset");

    a_hold: assert property (@(posedge clk_adc) disable iff (rst_i)
        (!$past(en_cdr_i) && !$past(rst_i)) |-> pi_code_o == $past(pi_code_o))
        else $error("pi_code_o moved while loop disabled");

    for (genvar k = 0; k < n_ti; k++) begin : g_slice
        a_reset_offset: assert property (@(posedge clk_adc)
            rst_i |=> (en_ext_offset_i || offset_o[k] == '0))
            else $error("calibrated offset not cleared by reset");

        a_offset: assert property (@(posedge clk_adc) disable iff (rst_i)
            en_ext_offset_i |-> offset_o[k] == ext_offset_i[k])
            else $error("offset_o does not follow ext_offset_i");

        // Frame sampled two edges back and offset sampled one edge back
        a_unfold: assert property (@(posedge clk_adc) disable iff (rst_i)
            ($past(en_ext_offset_i) && !$past(rst_i) && !$past(rst_i, 2)) |->
            int'(adc_unfolded_o[k]) == wrap9(signed_mag($past(adc_mag_i[k], 2),
                $past(adc_sign_i[k], 2)) - int'($past(ext_offset_i[k]))))
            else $error("unfolded sample wrong");
    end

    for (genvar j = 0; j < n_out; j++) begin : g_out
        a_reset_ctl: assert property (@(posedge clk_adc)
            rst_i |=> pi_ctl_o[j] == '0)
            else $error("pi_ctl_o not cleared by reset");

        a_scale: assert property (@(posedge clk_adc) disable iff (rst_i)
            !$past(rst_i) |-> int'(pi_ctl_o[j]) == ctl_value(int'($past(pi_code_o)),
                int'($past(ext_pi_offset_i[j])), int'($past(ext_scale_i[j]))))
            else $error("scaled interpolator control wrong");
    end

endmodule

bind cdr_core cdr_core_asserts u_asserts (
    .clk_adc         (clk_adc),
    .rst_i           (rst_i),
    .adc_mag_i       (adc_mag_i),
    .adc_sign_i      (adc_sign_i),
    .en_ext_offset_i (en_ext_offset_i),
    .ext_offset_i    (ext_offset_i),
    .en_cdr_i        (en_cdr_i),
    .ext_pi_offset_i (ext_pi_offset_i),
    .ext_scale_i     (ext_scale_i),
    .adc_unfolded_o  (adc_unfolded_o),
    .offset_o        (offset_o),
    .pi_code_o       (pi_code_o),
    .pi_ctl_o        (pi_ctl_o)
);

`default_nettype wire

/* verif/cdr_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cdr_core_tb;
    import adc_pack::*;
    import cdr_pack::*;

    localparam int avg_log2 = 4;
    localparam int kp_shift = 2;
    localparam int ki_shift = 6;
    localparam int n_reset = 8;
    localparam int n_ext = 40;
    localparam int n_cal = 40;
    localparam int n_loop = 80;
    localparam int n_scale = 40;
    // Phases plus control edges, reset and margin
    localparam int cycle_limit = 5 + n_reset + n_ext + n_cal + n_loop + n_scale + 10 + 50;
    localparam int code_mask = (1 << n_pi) - 1;

    logic clk_adc;
    logic rst_i;
    adc_mag_t adc_mag [n_ti-1:0];
    logic [n_ti-1:0] adc_sign;
    logic en_cal;
    logic en_ext_offset;
    logic en_cdr;
    adc_offset_t ext_offset [n_ti-1:0];
    pi_code_t ext_pi_offset [n_out-1:0];
    pi_scale_t ext_scale [n_out-1:0];
    wire adc_smp_t adc_unfolded [n_ti-1:0];
    wire adc_offset_t offset [n_ti-1:0];
    wire pi_code_t pi_code;
    wire pi_code_t pi_ctl [n_out-1:0];

    // Reference pipeline state
    int m_mag [n_ti];
    logic [n_ti-1:0] m_sign;
    int m_smp [n_ti];
    int m_acc [n_ti];
    int m_cal [n_ti];
    int m_cnt;
    int m_prev_last;
    int m_err;
    int m_integ;
    int m_code;
    int m_ctl [n_out];

    string cur_test;
    int test_errs;
    int tests_passed;
    int tests_failed;
    int cycle_cnt;
    bit checking;

    tb_clk_gen u_clk (.clk_o(clk_adc), .rst_o(rst_i));

    cdr_core #(.avg_log2(avg_log2), .kp_shift(kp_shift), .ki_shift(ki_shift)) u_dut (
        .clk_adc         (clk_adc),
        .rst_i           (rst_i),
        .adc_mag_i       (adc_mag),
        .adc_sign_i      (adc_sign),
        .en_cal_i        (en_cal),
        .en_ext_offset_i (en_ext_offset),
        .ext_offset_i    (ext_offset),
        .en_cdr_i        (en_cdr),
        .ext_pi_offset_i (ext_pi_offset),
        .ext_scale_i     (ext_scale),
        .adc_unfolded_o  (adc_unfolded),
        .offset_o        (offset),
        .pi_code_o       (pi_code),
        .pi_ctl_o        (pi_ctl)
    );

    function automatic int signed_mag(int m, logic s);
        return s ? m : -m;
    endfunction

    function automatic int wrap_smp(int v);
        adc_smp_t t;
        t = adc_smp_t'(v);
        return int'(t);
    endfunction

    function automatic int sgn(int v);
        return (v >= 0) ? 1 : -1;
    endfunction

    function automatic int offset_in_use(int k);
        return en_ext_offset ? int'(ext_offset[k]) : m_cal[k];
    endfunction

    function automatic int scaled_ctl(int code, int off, int scl);
        return (((code + off) & code_mask) * ((scl << 4) & code_mask)) >> n_pi;
    endfunction

    // Updated late stage first, so each stage sees last cycle's values
    always @(posedge clk_adc) begin
        int raw;
        int a;
        int b;
        int err;
        if (rst_i) begin
            for (int k = 0; k < n_ti; k++) begin
                m_mag[k] = 0;
                m_smp[k] = 0;
                m_acc[k] = 0;
                m_cal[k] = 0;
            end
            for (int j = 0; j < n_out; j++) begin
                m_ctl[j] = 0;
            end
            m_sign = '0;
            m_cnt = 0;
            m_prev_last = 0;
            m_err = 0;
            m_integ = 0;
            m_code = 0;
        end else begin
            for (int j = 0; j < n_out; j++) begin
                m_ctl[j] = scaled_ctl(m_code, int'(ext_pi_offset[j]), int'(ext_scale[j]));
            end
            if (en_cdr) begin
                m_integ = (m_integ + (m_err >>> ki_shift)) & code_mask;
                m_code = (m_integ + (m_err >>> kp_shift)) & code_mask;
            end
            err = 0;
            for (int k = 0; k < n_ti; k++) begin
                a = (k == 0) ? m_prev_last : m_smp[k-1];
                b = m_smp[k];
                err = err + a * sgn(b) - b * sgn(a);
            end
            m_prev_last = m_smp[n_ti-1];
            m_err = err;
            for (int k = 0; k < n_ti; k++) begin
                raw = signed_mag(m_mag[k], m_sign[k]);
                m_smp[k] = wrap_smp(raw - offset_in_use(k));
                if (!en_cal) begin
                    m_acc[k] = 0;
                end else if (m_cnt == (1 << avg_log2) - 1) begin
                    m_cal[k] = wrap_smp((m_acc[k] + raw) >>> avg_log2);
                    m_acc[k] = 0;
                end else begin
                    m_acc[k] = m_acc[k] + raw;
                end
            end
            if (!en_cal || m_cnt == (1 << avg_log2) - 1) begin
                m_cnt = 0;
            end else begin
                m_cnt = m_cnt + 1;
            end
            for (int k = 0; k < n_ti; k++) begin
                m_mag[k] = int'(adc_mag[k]);
            end
            m_sign = adc_sign;
        end
    end

    task automatic report_mismatch(string what, int exp, int act);
        $display("[ERROR] %s: %s expected %0d actual %0d", cur_test, what, exp, act);
        test_errs++;
    endtask

    // Outputs compared mid-cycle where they are stable
    always @(negedge clk_adc) begin
        if (!rst_i && checking) begin
            for (int k = 0; k < n_ti; k++) begin
                if (int'(adc_unfolded[k]) != m_smp[k]) begin
                    report_mismatch($sformatf("adc_unfolded_o[%0d]", k), m_smp[k],
                                    int'(adc_unfolded[k]));
                end
                if (int'(offset[k]) != offset_in_use(k)) begin
                    report_mismatch($sformatf("offset_o[%0d]", k), offset_in_use(k),
                                    int'(offset[k]));
                end
            end
            if (int'(pi_code) != m_code) begin
                report_mismatch("pi_code_o", m_code, int'(pi_code));
            end
            for (int j = 0; j < n_out; j++) begin
                if (int'(pi_ctl[j]) != m_ctl[j]) begin
                    report_mismatch($sformatf("pi_ctl_o[%0d]", j), m_ctl[j], int'(pi_ctl[j]));
                end
            end
        end
    end

    always @(posedge clk_adc) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic begin_test(string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        $display("test %s: %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "failed",
                 test_errs);
        if (test_errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
    endtask

    task automatic set_controls(logic cal, logic ext, logic cdr);
        @(posedge clk_adc);
        en_cal <= cal;
        en_ext_offset <= ext;
        en_cdr <= cdr;
    endtask

    task automatic run_cycles(int n, bit new_frame, bit new_cfg);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_adc);
            if (new_frame) begin
                for (int k = 0; k < n_ti; k++) begin
                    adc_mag[k] <= adc_mag_t'($urandom);
                end
                adc_sign <= (n_ti)'($urandom);
            end
            if (new_cfg) begin
                for (int k = 0; k < n_ti; k++) begin
                    ext_offset[k] <= adc_offset_t'($urandom);
                end
                for (int j = 0; j < n_out; j++) begin
                    ext_pi_offset[j] <= pi_code_t'($urandom);
                    ext_scale[j] <= pi_scale_t'($urandom);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'h5aac));
        // Live frames and a running loop while reset is held
        for (int k = 0; k < n_ti; k++) begin
            adc_mag[k] = adc_mag_t'($urandom);
            ext_offset[k] = '0;
        end
        for (int j = 0; j < n_out; j++) begin
            ext_pi_offset[j] = '0;
            ext_scale[j] = pi_scale_t'(8'h0f);
        end
        adc_sign = (n_ti)'($urandom);
        en_cal = 1'b0;
        en_ext_offset = 1'b0;
        en_cdr = 1'b1;
        checking = 1'b0;
        @(posedge clk_adc);
        while (rst_i) @(posedge clk_adc);
        checking = 1'b1;

        begin_test("reset");
        run_cycles(n_reset, 1, 0);
        end_test();

        begin_test("ext_offset");
        set_controls(1'b0, 1'b1, 1'b0);
        run_cycles(n_ext, 1, 1);
        end_test();

        begin_test("calibration");
        set_controls(1'b1, 1'b0, 1'b0);
        run_cycles(1, 1, 0);
        run_cycles(n_cal, 0, 0);
        end_test();

        begin_test("loop");
        set_controls(1'b0, 1'b0, 1'b1);
        run_cycles(n_loop - 20, 1, 0);
        set_controls(1'b0, 1'b0, 1'b0);
        run_cycles(20, 1, 0);
        end_test();

        begin_test("scaling");
        set_controls(1'b0, 1'b0, 1'b1);
        run_cycles(n_scale, 1, 1);
        end_test();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
common/adc_pack.sv
common/cdr_pack.sv
src/adc_retimer.sv
src/adc_unfold.sv
cdr/mm_pd.sv
cdr/cdr_loop_filter.sv
cdr/pi_scaler.sv
src/cdr_core.sv
verif/tb_clk_gen.sv
verif/cdr_core_asserts.sv
verif/cdr_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module cdr_core_tb -o sim_cdr_core

out=$(./obj_dir/sim_cdr_core 2>&1) || true
echo "$out"

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
    exit 0
else
    exit 1
fi
